// ==== bomb_pkg.sv ====
package bomb_pkg;

  // ------------------------------------------------------------
  // Tile codes held in the map
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    TILE_EMPTY = 2'd0,  // Walkable
    TILE_SOLID = 2'd1,  // Indestructible wall
    TILE_BRICK = 2'd2,  // Destroyed by a blast
    TILE_SPARE = 2'd3
  } tile_code_t;

  localparam int CFG_W = 16;  // Config bus width

  // One config word, two decodings picked by cfg_sel
  typedef union packed {
    struct packed {
      logic [7:0] tick_div;    // Cycles per tick
      logic [7:0] fuse_ticks;  // Ticks per explosion
    } timing;
    struct packed {
      logic [7:0]        tile_addr;
      logic [CFG_W-11:0] unused;     // 6 spare bits
      tile_code_t        tile_code;
    } tile;
  } cfg_word_u;

  // ------------------------------------------------------------
  // Blast cross test, radius one, row and column compared apart
  // ------------------------------------------------------------
  function automatic logic in_blast(input logic [7:0] addr, input logic [7:0] centre,
                                    input int num_row, input int num_col);
    int a_row, a_col, c_row, c_col, d_row, d_col;
    a_row = int'(addr) / num_col;
    a_col = int'(addr) % num_col;
    c_row = int'(centre) / num_col;
    c_col = int'(centre) % num_col;
    d_row = (a_row > c_row) ? a_row - c_row : c_row - a_row;
    d_col = (a_col > c_col) ? a_col - c_col : c_col - a_col;
    // Both inside the map, Manhattan distance at most one
    return (int'(addr) < num_row * num_col) && (int'(centre) < num_row * num_col) &&
           (d_row + d_col <= 1);
  endfunction

endpackage

// ==== bomb_ctrl_regs.sv ====
`timescale 1ns/10ps

module bomb_ctrl_regs
  import bomb_pkg::*;
#(
  parameter int NUM_ROW      = 11,
  parameter int NUM_COL      = 19,
  parameter int TICK_DIV_RST = 250,  // Divider after reset
  parameter int FUSE_RST     = 3,    // Fuse length after reset
  localparam int ADDR_W      = $clog2(NUM_ROW * NUM_COL)
)(
  input  logic              clk,
  input  logic              rst,
  input  logic              cfg_we,      // One-cycle write strobe
  input  logic              cfg_sel,     // 0 timing view, 1 tile view
  input  cfg_word_u         cfg_wdata,
  output logic [7:0]        fuse_ticks,
  output logic              tick,        // One-cycle pulse
  output logic              tile_we,
  output logic [ADDR_W-1:0] tile_waddr,
  output tile_code_t        tile_wcode
);

  logic [7:0] tick_div;   // Raw divider setting
  logic [7:0] div_cnt;    // Cycle counter within one tick period
  logic [7:0] div_last;   // Terminal count
  logic       timing_we;

  // ------------------------------------------------------------
  // Decode of the config word
  // ------------------------------------------------------------
  assign timing_we  = cfg_we && !cfg_sel;
  assign tile_we    = cfg_we && cfg_sel;                      // Forwarded to the map
  assign tile_waddr = cfg_wdata.tile.tile_addr[ADDR_W-1:0];
  assign tile_wcode = cfg_wdata.tile.tile_code;

  // Timing registers
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tick_div   <= 8'(TICK_DIV_RST);
      fuse_ticks <= 8'(FUSE_RST);
    end
    else if (timing_we)
    begin
      tick_div   <= cfg_wdata.timing.tick_div;
      fuse_ticks <= cfg_wdata.timing.fuse_ticks;
    end
  end

  // ------------------------------------------------------------
  // Tick divider
  // ------------------------------------------------------------
  // Divider of 0 behaves like 1, so tick every cycle
  assign div_last = (tick_div == 8'd0) ? 8'd0 : tick_div - 8'd1;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      div_cnt <= 8'd0;
      tick    <= 1'b0;
    end
    else if (timing_we)  // New timing restarts the period
    begin
      div_cnt <= 8'd0;
      tick    <= 1'b0;
    end
    else if (div_cnt >= div_last)
    begin
      div_cnt <= 8'd0;
      tick    <= 1'b1;   // Last cycle of the period
    end
    else
    begin
      div_cnt <= div_cnt + 8'd1;
      tick    <= 1'b0;
    end
  end

endmodule

// ==== explode_logic.sv ====
`timescale 1ns/10ps

module explode_logic
  import bomb_pkg::*;
#(
  parameter int NUM_ROW   = 11,
  parameter int NUM_COL   = 19,
  parameter int TILE_PX   = 64,   // Power of two
  parameter int SPRITE_W  = 32,
  parameter int SPRITE_H  = 48,
  localparam int ADDR_W   = $clog2(NUM_ROW * NUM_COL)
)(
  input  logic              clk,
  input  logic              rst,
  input  logic              tick,
  input  logic [7:0]        fuse_ticks,
  input  logic              trigger_explosion,   // Strobe, only taken in IDLE
  input  logic [ADDR_W-1:0] explosion_addr,
  input  logic [10:0]       player_x,            // Map pixel coordinates
  input  logic [9:0]        player_y,
  output logic [ADDR_W-1:0] saved_explosion_addr,
  output logic              explode_signal,
  output logic              free_blks_signal,
  output logic              game_over
);

  localparam int TILE_SHIFT = $clog2(TILE_PX);

  // State encoding
  localparam logic [1:0] IDLE      = 2'd0;
  localparam logic [1:0] EXPLODE   = 2'd1;
  localparam logic [1:0] FREE_BLKS = 2'd2;

  logic [1:0] st, nst;
  logic [7:0] fuse_cnt;   // Ticks seen so far in EXPLODE
  logic       fuse_done;  // This tick is the last one

  // ------------------------------------------------------------
  // Bomb FSM
  // ------------------------------------------------------------
  // Fuse of 0 ends on the first tick, same as 1
  assign fuse_done = tick && ({1'b0, fuse_cnt} + 9'd1 >= {1'b0, fuse_ticks});

  always_ff @(posedge clk)
  begin
    if (rst)
      st <= IDLE;
    else
      st <= nst;
  end

  always_comb
  begin
    nst = st;
    case (st)
      IDLE:      if (trigger_explosion) nst = EXPLODE;
      EXPLODE:   if (fuse_done) nst = FREE_BLKS;
      FREE_BLKS: nst = IDLE;                     // Single clearing cycle
      default:   nst = IDLE;
    endcase
  end

  // Fuse counter and blast centre
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      fuse_cnt             <= 8'd0;
      saved_explosion_addr <= '0;
    end
    else
    begin
      case (st)
        IDLE:
        begin
          fuse_cnt <= 8'd0;
          if (trigger_explosion)
            saved_explosion_addr <= explosion_addr;  // Held until next bomb
        end
        EXPLODE:
          if (tick) fuse_cnt <= fuse_cnt + 8'd1;
        default:
          fuse_cnt <= 8'd0;
      endcase
    end
  end

  assign explode_signal   = (st == EXPLODE);
  assign free_blks_signal = (st == FREE_BLKS);

  // ------------------------------------------------------------
  // Player contact
  // ------------------------------------------------------------
  logic [11:0] x_l, x_r;      // Left and right pixel columns
  logic [10:0] y_t, y_b;      // Top and bottom pixel rows
  logic [11:0] col_l, col_r;  // Tile columns under the sprite
  logic [10:0] row_t, row_b;  // Tile rows under the sprite
  logic        hit;

  assign x_l = {1'b0, player_x};
  assign x_r = x_l + 12'(SPRITE_W - 1);   // Extra bit, no overflow
  assign y_t = {1'b0, player_y};
  assign y_b = y_t + 11'(SPRITE_H - 1);

  assign col_l = x_l >> TILE_SHIFT;
  assign col_r = x_r >> TILE_SHIFT;
  assign row_t = y_t >> TILE_SHIFT;
  assign row_b = y_b >> TILE_SHIFT;

  // Tile under the sprite inside the map and inside the cross
  function automatic logic tile_hit(input logic [10:0] row, input logic [11:0] col,
                                    input logic [ADDR_W-1:0] centre);
    int addr;
    addr = int'(row) * NUM_COL + int'(col);
    // Column bound stops a right-edge tile aliasing into the next row
    return (int'(row) < NUM_ROW) && (int'(col) < NUM_COL) &&
           in_blast(8'(addr), 8'(centre), NUM_ROW, NUM_COL);
  endfunction

  // Up to four distinct tiles, duplicates are harmless
  assign hit = tile_hit(row_t, col_l, saved_explosion_addr) ||
               tile_hit(row_t, col_r, saved_explosion_addr) ||
               tile_hit(row_b, col_l, saved_explosion_addr) ||
               tile_hit(row_b, col_r, saved_explosion_addr);

  assign game_over = explode_signal && hit;  // Only while the blast is live

endmodule

// ==== blast_map.sv ====
`timescale 1ns/10ps

module blast_map
  import bomb_pkg::*;
#(
  parameter int NUM_ROW  = 11,
  parameter int NUM_COL  = 19,
  localparam int DEPTH   = NUM_ROW * NUM_COL,
  localparam int ADDR_W  = $clog2(DEPTH)
)(
  input  logic              clk,
  input  logic              rst,
  input  logic              tile_we,
  input  logic [ADDR_W-1:0] tile_waddr,
  input  tile_code_t        tile_wcode,
  input  logic              free_blks_signal,     // One-cycle clear request
  input  logic [ADDR_W-1:0] saved_explosion_addr,
  input  logic [ADDR_W-1:0] rd_addr,
  output tile_code_t        rd_tile
);

  tile_code_t       map_q [DEPTH];  // Row-major, addr = row*NUM_COL + col
  logic [DEPTH-1:0] clr_hit;        // Per-tile clear enable
  logic             wr_ok;

  // ------------------------------------------------------------
  // Clear and write decode
  // ------------------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < DEPTH; i++)
    begin
      // Only bricks inside the cross, solid tiles survive
      clr_hit[i] = free_blks_signal && (map_q[i] == TILE_BRICK) &&
                   in_blast(8'(i), 8'(saved_explosion_addr), NUM_ROW, NUM_COL);
    end
  end

  assign wr_ok = tile_we && (int'(tile_waddr) < DEPTH);  // Drop writes off the map

  // ------------------------------------------------------------
  // Tile storage
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < DEPTH; i++)
        map_q[i] <= TILE_EMPTY;
    end
    else
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        if (clr_hit[i])
          map_q[i] <= TILE_EMPTY;                // Clear beats a same-cycle write
        else if (wr_ok && (tile_waddr == ADDR_W'(i)))
          map_q[i] <= tile_wcode;
      end
    end
  end

  // Combinational read, off-map reads as empty
  always_comb
  begin
    rd_tile = TILE_EMPTY;
    if (int'(rd_addr) < DEPTH)
      rd_tile = map_q[rd_addr];
  end

endmodule

// ==== bomb_top.sv ====
`timescale 1ns/10ps

module bomb_top
  import bomb_pkg::*;
#(
  parameter int NUM_ROW      = 11,
  parameter int NUM_COL      = 19,
  parameter int TILE_PX      = 64,
  parameter int SPRITE_W     = 32,
  parameter int SPRITE_H     = 48,
  parameter int TICK_DIV_RST = 250,
  parameter int FUSE_RST     = 3,
  localparam int ADDR_W      = $clog2(NUM_ROW * NUM_COL)
)(
  input  logic              clk,
  input  logic              rst,
  // Config port
  input  logic              cfg_we,
  input  logic              cfg_sel,
  input  cfg_word_u         cfg_wdata,
  // Bomb and player
  input  logic              trigger_explosion,
  input  logic [ADDR_W-1:0] explosion_addr,
  input  logic [10:0]       player_x,
  input  logic [9:0]        player_y,
  // Map read
  input  logic [ADDR_W-1:0] rd_addr,
  output tile_code_t        rd_tile,
  // Blast status
  output logic [ADDR_W-1:0] saved_explosion_addr,
  output logic              explode_signal,
  output logic              free_blks_signal,
  output logic              game_over
);

  logic              tick;
  logic [7:0]        fuse_ticks;
  logic              tile_we;
  logic [ADDR_W-1:0] tile_waddr;
  tile_code_t        tile_wcode;

  // Config carries an 8-bit tile address
  if (ADDR_W > 8)
  begin : g_addr_chk
    $error("map of %0d tiles needs more than 8 address bits", NUM_ROW * NUM_COL);
  end

  // ------------------------------------------------------------
  // Blocks
  // ------------------------------------------------------------
  bomb_ctrl_regs #(
    .NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL),
    .TICK_DIV_RST(TICK_DIV_RST), .FUSE_RST(FUSE_RST)
  ) bomb_ctrl_regs_i (
    .clk, .rst, .cfg_we, .cfg_sel, .cfg_wdata,
    .fuse_ticks, .tick, .tile_we, .tile_waddr, .tile_wcode
  );

  explode_logic #(
    .NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL), .TILE_PX(TILE_PX),
    .SPRITE_W(SPRITE_W), .SPRITE_H(SPRITE_H)
  ) explode_logic_i (
    .clk, .rst, .tick, .fuse_ticks, .trigger_explosion, .explosion_addr,
    .player_x, .player_y, .saved_explosion_addr, .explode_signal,
    .free_blks_signal, .game_over
  );

  blast_map #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) blast_map_i (
    .clk, .rst, .tile_we, .tile_waddr, .tile_wcode, .free_blks_signal,
    .saved_explosion_addr, .rd_addr, .rd_tile
  );

endmodule

// ==== bomb_sva.sv ====
`timescale 1ns/10ps

module bomb_sva #(
  parameter int ADDR_W = 8
)(
  input logic              clk,
  input logic              rst,
  input logic              tick,
  input logic [ADDR_W-1:0] saved_explosion_addr,
  input logic              explode_signal,
  input logic              free_blks_signal
);

  // ------------------------------------------------------------
  // Phase outputs of the bomb FSM
  // ------------------------------------------------------------
  // Blast cannot end without a tick
  a_fuse_tick: assert property (@(posedge clk) disable iff (rst)
    explode_signal && !tick |=> explode_signal)
    else $error("explode_signal ended on a cycle without a tick");

  // Clearing is a single cycle
  a_free_pulse: assert property (@(posedge clk) disable iff (rst)
    free_blks_signal |=> !free_blks_signal)
    else $error("free_blks_signal high for more than one cycle");

  // Centre is frozen once the blast is live
  a_centre_hold: assert property (@(posedge clk) disable iff (rst)
    explode_signal |=> $stable(saved_explosion_addr))
    else $error("saved_explosion_addr changed during the explosion");

endmodule

bind explode_logic bomb_sva #(.ADDR_W(ADDR_W)) bomb_sva_i (
  .clk                  (clk),
  .rst                  (rst),
  .tick                 (tick),
  .saved_explosion_addr (saved_explosion_addr),
  .explode_signal       (explode_signal),
  .free_blks_signal     (free_blks_signal)
);

// ==== bomb_tb.sv ====
`timescale 1ns/10ps

module bomb_tb
  import bomb_pkg::*;
();

  localparam int NUM_ROW  = 11;
  localparam int NUM_COL  = 19;
  localparam int TILE_PX  = 64;
  localparam int SPRITE_W = 32;
  localparam int SPRITE_H = 48;
  localparam int DEPTH    = NUM_ROW * NUM_COL;
  localparam int MAX_CYC  = 20000;  // About four times the longest run

  logic        clk = 1'b0;
  logic        rst;
  logic        cfg_we;
  logic        cfg_sel;
  cfg_word_u   cfg_wdata;
  logic        trigger_explosion;
  logic [7:0]  explosion_addr;
  logic [10:0] player_x;
  logic [9:0]  player_y;
  logic [7:0]  rd_addr;
  tile_code_t  rd_tile;
  logic [7:0]  saved_explosion_addr;
  logic        explode_signal;
  logic        free_blks_signal;
  logic        game_over;

  tile_code_t shadow [DEPTH];      // Expected map
  logic [7:0] exp_centre;          // Last bomb the TB fired
  int         cur_div;             // Effective divider and fuse
  int         cur_fuse;
  int         seed = 51;
  int         cycles;
  int         errs;
  int         pass_cnt;
  int         fail_cnt;
  int         centres [8] = '{104, 0, 18, 190, 208, 19, 37, 9};  // Middle, corners, edges
  string      test_name;

  bomb_top #(
    .NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL), .TILE_PX(TILE_PX),
    .SPRITE_W(SPRITE_W), .SPRITE_H(SPRITE_H), .TICK_DIV_RST(4), .FUSE_RST(3)
  ) bomb_top_i (.*);

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYC)
    begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic bit ref_in_blast(input int addr, input int centre);
    int ar, ac, cr, cc;
    if (addr >= DEPTH || centre >= DEPTH)
      return 1'b0;
    ar = addr / NUM_COL;
    ac = addr % NUM_COL;
    cr = centre / NUM_COL;
    cc = centre % NUM_COL;
    if (ar == cr)
      return (ac - cc <= 1) && (cc - ac <= 1);  // Same row, no wrap
    return (ac == cc) && (ar - cr <= 1) && (cr - ar <= 1);
  endfunction

  function automatic bit ref_game_over(input int x, input int y, input int centre);
    int cols [2];
    int rows [2];
    bit hit;
    cols[0] = x / TILE_PX;
    cols[1] = (x + SPRITE_W - 1) / TILE_PX;
    rows[0] = y / TILE_PX;
    rows[1] = (y + SPRITE_H - 1) / TILE_PX;
    hit = 1'b0;
    foreach (rows[r])
      foreach (cols[c])
        if (rows[r] < NUM_ROW && cols[c] < NUM_COL)  // Off-map corners never hit
          hit |= ref_in_blast(rows[r] * NUM_COL + cols[c], centre);
    return hit;
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // game_over and blast centre on every cycle
  always @(negedge clk)
  begin
    bit exp_go;
    if (!rst)
    begin
      exp_go = explode_signal && ref_game_over(player_x, player_y, exp_centre);
      if (game_over !== exp_go)
      begin
        $display("MISMATCH %s game_over: expected %0d actual %0d", test_name, exp_go, game_over);
        errs++;
      end
      if (explode_signal && saved_explosion_addr !== exp_centre)
      begin
        $display("MISMATCH %s centre: expected %0d actual %0d", test_name, exp_centre,
                 saved_explosion_addr);
        errs++;
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus tasks, all start and end 1 ns after a rising edge
  // ------------------------------------------------------------
  task automatic write_tile(input int addr, input tile_code_t code);
    cfg_we    = 1'b1;
    cfg_sel   = 1'b1;                  // Tile view
    cfg_wdata = '0;
    cfg_wdata.tile.tile_addr = 8'(addr);
    cfg_wdata.tile.tile_code = code;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    if (addr < DEPTH)
      shadow[addr] = code;             // Off-map writes leave the map alone
  endtask

  task automatic write_timing(input int div, input int fuse);
    cfg_we    = 1'b1;
    cfg_sel   = 1'b0;
    cfg_wdata.timing.tick_div   = 8'(div);
    cfg_wdata.timing.fuse_ticks = 8'(fuse);
    @(posedge clk);
    #1;
    cfg_we   = 1'b0;
    cur_div  = (div == 0) ? 1 : div;   // Zero acts as one
    cur_fuse = (fuse == 0) ? 1 : fuse;
  endtask

  task automatic check_tile(input int addr);
    rd_addr = 8'(addr);
    @(negedge clk);
    if (rd_tile !== shadow[addr])
    begin
      $display("MISMATCH %s tile %0d: expected %0d actual %0d", test_name, addr,
               shadow[addr], rd_tile);
      errs++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_map();
    for (int i = 0; i < DEPTH; i++)
      check_tile(i);
  endtask

  // Mix of empty, solid and brick over the whole address
  task automatic fill_map(input int salt);
    int v;
    for (int i = 0; i < DEPTH; i++)
    begin
      v = (i * 37 + (i >> 2) + salt) % 4;
      write_tile(i, (v == 0) ? TILE_EMPTY : (v == 1) ? TILE_SOLID : TILE_BRICK);
    end
  endtask

  // Sprite somewhere within two tiles of the centre
  task automatic place_player(input int centre);
    int x, y;
    x = (centre % NUM_COL - 2) * TILE_PX + rand_below(5 * TILE_PX);
    y = (centre / NUM_COL - 2) * TILE_PX + rand_below(5 * TILE_PX);
    player_x = (x < 0) ? 11'd0 : 11'(x);
    player_y = (y < 0) ? 10'd0 : 10'(y);
  endtask

  // Fire one bomb, optionally retrigger at another address mid-blast
  task automatic run_bomb(input int addr, input int retrig_addr, input bit rand_player);
    int len, frees, lo, hi;
    len   = 0;
    frees = 0;
    trigger_explosion = 1'b1;
    explosion_addr    = 8'(addr);
    exp_centre        = 8'(addr);
    @(posedge clk);
    #1;
    trigger_explosion = 1'b0;
    while (explode_signal)
    begin
      if (len == 2 && retrig_addr >= 0)
      begin
        trigger_explosion = 1'b1;        // Must be ignored
        explosion_addr    = 8'(retrig_addr);
      end
      if (rand_player)
        place_player(addr);
      @(posedge clk);
      #1;
      trigger_explosion = 1'b0;
      len++;
    end
    for (int k = 0; k < 3; k++)
    begin
      if (free_blks_signal)
        frees++;
      @(posedge clk);
      #1;
    end
    for (int i = 0; i < DEPTH; i++)
      if (shadow[i] == TILE_BRICK && ref_in_blast(i, addr))
        shadow[i] = TILE_EMPTY;          // Bricks in the cross go
    lo = (cur_fuse - 1) * cur_div + 1;
    hi = cur_fuse * cur_div;
    if (len < lo || len > hi)
    begin
      $display("%s: explosion at %0d lasted %0d cycles, outside %0d to %0d",
               test_name, addr, len, lo, hi);
      errs++;
    end
    if (frees != 1)
    begin
      $display("%s: free_blks_signal was high %0d cycles instead of one", test_name, frees);
      errs++;
    end
    if (saved_explosion_addr !== 8'(addr))
    begin
      $display("MISMATCH %s saved centre: expected %0d actual %0d", test_name, addr,
               saved_explosion_addr);
      errs++;
    end
  endtask

  task automatic finish_test();
    if (errs == 0)
    begin
      pass_cnt++;
      $display("PASS %s", test_name);
    end
    else
    begin
      fail_cnt++;
      $display("FAIL %s with %0d errors", test_name, errs);
    end
    errs = 0;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial
  begin
    int a;
    rst               = 1'b1;
    cfg_we            = 1'b0;
    cfg_sel           = 1'b0;
    cfg_wdata         = '0;
    trigger_explosion = 1'b0;
    explosion_addr    = 8'd0;
    player_x          = 11'd0;
    player_y          = 10'd0;
    rd_addr           = 8'd0;
    exp_centre        = 8'd0;
    cur_div           = 4;               // Reset timing
    cur_fuse          = 3;
    test_name         = "reset";
    foreach (shadow[i])
      shadow[i] = TILE_EMPTY;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    if (explode_signal !== 1'b0 || free_blks_signal !== 1'b0 || game_over !== 1'b0)
    begin
      $display("%s: blast outputs are not low after reset", test_name);
      errs++;
    end
    check_map();
    finish_test();

    test_name = "tile_write";
    repeat (40)
    begin
      a = rand_below(DEPTH);
      write_tile(a, tile_code_t'(rand_below(4)));
      check_tile(a);
    end
    write_tile(230, TILE_SOLID);         // Off the map
    check_map();
    finish_test();

    test_name = "blast_clear";
    foreach (centres[n])
    begin
      fill_map(n);
      write_tile(centres[n], TILE_BRICK);
      if (centres[n] > 0)
        write_tile(centres[n] - 1, TILE_BRICK);     // Previous row end at column 0
      if (centres[n] + 1 < DEPTH)
        write_tile(centres[n] + 1, TILE_BRICK);
      if (centres[n] + NUM_COL < DEPTH)
        write_tile(centres[n] + NUM_COL, TILE_SOLID);
      run_bomb(centres[n], -1, 1'b0);
      check_map();
    end
    finish_test();

    test_name = "fuse_window";
    write_timing(3, 5);
    run_bomb(rand_below(DEPTH), -1, 1'b0);
    write_timing(1, 2);
    run_bomb(rand_below(DEPTH), -1, 1'b0);
    write_timing(6, 1);
    run_bomb(rand_below(DEPTH), -1, 1'b0);
    finish_test();

    test_name = "game_over";
    write_timing(8, 8);                  // Long blast, many samples
    repeat (4) run_bomb(rand_below(DEPTH), -1, 1'b1);
    finish_test();

    test_name = "retrigger";
    write_timing(4, 3);
    fill_map(9);
    run_bomb(104, 60, 1'b0);
    check_map();
    finish_test();

    $display("Tests done: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== filelist.f ====
bomb_pkg.sv
bomb_ctrl_regs.sv
explode_logic.sv
blast_map.sv
bomb_top.sv
bomb_sva.sv
bomb_tb.sv

// ==== Bender.yml ====
package:
  name: bomb_blast

sources:
  - bomb_pkg.sv
  - bomb_ctrl_regs.sv
  - explode_logic.sv
  - blast_map.sv
  - bomb_top.sv
  - target: test
    files:
      - bomb_sva.sv
      - bomb_tb.sv
